// ==== src/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Core address width
`define LSU_ADDR_W 32

// SRAM depth in 32-bit words
// Higher word addresses answer SLVERR
`define LSU_SRAM_WORDS 1024

// Rotating ready pattern of the slave
// A clear bit 0 holds arready/awready/wready low for that cycle
`define LSU_SRAM_WAIT 4'b0110

`endif

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  // Same encoding as AXI arsize/awsize
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  // One bus word seen as byte lanes or halfword lanes
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } bus_word_u;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== src/store_align.sv ====
module store_align (
  input  logic [31:0]    wsrc_q,
  input  logic [1:0]     addr_lo,
  input  lsu_pkg::size_e size_q,
  output logic [31:0]    wdata,
  output logic [3:0]     wstrb
);

  lsu_pkg::bus_word_u word;

  always_comb begin
    word  = '0;
    wstrb = 4'b0000;
    case (size_q)
      lsu_pkg::size_byte: begin
        word.bytes[addr_lo] = wsrc_q[7:0];
        wstrb[addr_lo]      = 1'b1;
      end
      lsu_pkg::size_half: begin
        // Aligned half so bit 0 of the offset is zero
        word.halves[addr_lo[1]] = wsrc_q[15:0];
        wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        word  = wsrc_q;
        wstrb = 4'b1111;
      end
    endcase
  end

  assign wdata = word;

endmodule

// ==== src/load_extract.sv ====
module load_extract (
  input  logic [31:0]    rdata,
  input  logic [1:0]     addr_lo,
  input  lsu_pkg::size_e size_q,
  input  logic           sext_q,
  output logic [31:0]    ext_data
);

  lsu_pkg::bus_word_u word;
  logic [7:0]         lane_b;
  logic [15:0]        lane_h;
  logic               sign_b;
  logic               sign_h;

  assign word   = rdata;
  assign lane_b = word.bytes[addr_lo];
  assign lane_h = word.halves[addr_lo[1]];

  // Fill bit is zero for unsigned loads
  assign sign_b = sext_q & lane_b[7];
  assign sign_h = sext_q & lane_h[15];

  always_comb begin
    case (size_q)
      lsu_pkg::size_byte: ext_data = {{24{sign_b}}, lane_b};
      lsu_pkg::size_half: ext_data = {{16{sign_h}}, lane_h};
      default:            ext_data = rdata;  // Word as is
    endcase
  end

endmodule

// ==== src/lsu_ctrl.sv ====
`include "lsu_settings.svh"

module lsu_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ren,
  input  logic                   wen,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [31:0]            wsrc,
  input  lsu_pkg::size_e         size,
  input  logic                   sext,
  input  logic [31:0]            exu_r_wdata,
  input  logic [31:0]            ext_data,
  input  logic                   arready,
  input  logic                   rvalid,
  input  logic [1:0]             rresp,
  input  logic                   awready,
  input  logic                   wready,
  input  logic                   bvalid,
  input  logic [1:0]             bresp,
  output logic [31:0]            r_wdata,
  output logic                   block,
  output logic                   fault,
  output logic [`LSU_ADDR_W-1:0] addr_q,
  output lsu_pkg::size_e         size_q,
  output logic                   sext_q,
  output logic [31:0]            wsrc_q,
  output logic                   arvalid,
  output logic                   rready,
  output logic                   awvalid,
  output logic                   wvalid,
  output logic                   bready
);

  logic take;
  logic ar_done;
  logic r_done;
  logic aw_done;
  logic w_done;
  logic b_done;

  assign take    = ~block & (ren | wen);  // New request accepted
  assign ar_done = arvalid & arready;
  assign r_done  = rready & rvalid;
  assign aw_done = awvalid & awready;
  assign w_done  = wvalid & wready;
  assign b_done  = bready & bvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      block   <= 1'b0;
      fault   <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      fault <= 1'b0;  // Single cycle pulse

      if (take) begin
        block   <= 1'b1;
        arvalid <= ren;
        awvalid <= wen;  // AW and W raised together
        wvalid  <= wen;
      end

      if (ar_done) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end

      if (r_done) begin
        rready <= 1'b0;
        block  <= 1'b0;
        fault  <= (rresp != lsu_pkg::resp_okay);
      end

      if (aw_done)
        awvalid <= 1'b0;

      if (w_done) begin
        wvalid <= 1'b0;
        bready <= 1'b1;
      end

      if (b_done) begin
        bready <= 1'b0;
        block  <= 1'b0;
        fault  <= (bresp != lsu_pkg::resp_okay);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      addr_q <= addr;
      size_q <= size;
      sext_q <= sext;
      wsrc_q <= wsrc;
    end

    // Idle pass-through of the execute result
    if (!block)
      r_wdata <= exu_r_wdata;
    else if (r_done)
      r_wdata <= (rresp == lsu_pkg::resp_okay) ? ext_data : 32'd0;
  end

endmodule

// ==== src/axi_sram.sv ====
`include "lsu_settings.svh"

module axi_sram (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`LSU_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  input  logic                   rready,
  input  logic [`LSU_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  input  logic                   bready,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  output logic                   awready,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid
);

  localparam int idx_w = $clog2(`LSU_SRAM_WORDS);

  logic [31:0]            mem [`LSU_SRAM_WORDS];
  logic [3:0]             wait_pat;
  logic                   busy;
  logic                   aw_held;
  logic                   w_held;
  logic [`LSU_ADDR_W-1:0] awaddr_q;
  logic [31:0]            wdata_q;
  logic [3:0]             wstrb_q;
  logic                   ar_hs;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   wr_fire;
  logic [`LSU_ADDR_W-1:0] wr_addr;
  logic [31:0]            wr_data;
  logic [3:0]             wr_strb;

  function automatic logic in_range(input logic [`LSU_ADDR_W-1:0] a);
    return a[`LSU_ADDR_W-1:2] < `LSU_SRAM_WORDS;
  endfunction

  // One access at a time
  // A pending response holds off new requests
  assign busy    = rvalid | bvalid;
  assign arready = wait_pat[0] & ~busy & ~aw_held & ~w_held;
  assign awready = wait_pat[0] & ~busy & ~aw_held;
  assign wready  = wait_pat[0] & ~busy & ~w_held;

  assign ar_hs = arvalid & arready;
  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  // AW and W may arrive in either order
  assign wr_addr = aw_held ? awaddr_q : awaddr;
  assign wr_data = w_held ? wdata_q : wdata;
  assign wr_strb = w_held ? wstrb_q : wstrb;
  assign wr_fire = (aw_held | aw_hs) & (w_held | w_hs);

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_pat <= `LSU_SRAM_WAIT;
      rvalid   <= 1'b0;
      bvalid   <= 1'b0;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
    end else begin
      wait_pat <= {wait_pat[0], wait_pat[3:1]};

      if (ar_hs)
        rvalid <= 1'b1;
      else if (rvalid & rready)
        rvalid <= 1'b0;

      if (wr_fire) begin
        bvalid  <= 1'b1;
        aw_held <= 1'b0;
        w_held  <= 1'b0;
      end else begin
        if (aw_hs)
          aw_held <= 1'b1;
        if (w_hs)
          w_held <= 1'b1;
        if (bvalid & bready)
          bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs)
      awaddr_q <= awaddr;
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end

    if (ar_hs) begin
      if (in_range(araddr)) begin
        rdata <= mem[araddr[idx_w+1:2]];
        rresp <= lsu_pkg::resp_okay;
      end else begin
        rdata <= 32'd0;
        rresp <= lsu_pkg::resp_slverr;
      end
    end

    if (wr_fire) begin
      bresp <= in_range(wr_addr) ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
      if (in_range(wr_addr)) begin
        for (int i = 0; i < 4; i++) begin
          if (wr_strb[i])
            mem[wr_addr[idx_w+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== src/lsu_top.sv ====
`include "lsu_settings.svh"

module lsu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ren,
  input  logic                   wen,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [31:0]            wsrc,
  input  lsu_pkg::size_e         size,
  input  logic                   sext,
  input  logic [31:0]            exu_r_wdata,
  output logic [31:0]            r_wdata,
  output logic                   block,
  output logic                   fault
);

  logic [`LSU_ADDR_W-1:0] addr_q;
  lsu_pkg::size_e         size_q;
  logic                   sext_q;
  logic [31:0]            wsrc_q;
  logic [31:0]            ext_data;
  logic                   arvalid;
  logic                   arready;
  logic                   rready;
  logic                   rvalid;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   awvalid;
  logic                   awready;
  logic                   wvalid;
  logic                   wready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   bready;
  logic                   bvalid;
  logic [1:0]             bresp;

  lsu_ctrl ctrl0 (
    .clock       (clock),
    .reset       (reset),
    .ren         (ren),
    .wen         (wen),
    .addr        (addr),
    .wsrc        (wsrc),
    .size        (size),
    .sext        (sext),
    .exu_r_wdata (exu_r_wdata),
    .ext_data    (ext_data),
    .arready     (arready),
    .rvalid      (rvalid),
    .rresp       (rresp),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .r_wdata     (r_wdata),
    .block       (block),
    .fault       (fault),
    .addr_q      (addr_q),
    .size_q      (size_q),
    .sext_q      (sext_q),
    .wsrc_q      (wsrc_q),
    .arvalid     (arvalid),
    .rready      (rready),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .bready      (bready)
  );

  store_align store_align0 (
    .wsrc_q  (wsrc_q),
    .addr_lo (addr_q[1:0]),
    .size_q  (size_q),
    .wdata   (wdata),
    .wstrb   (wstrb)
  );

  load_extract load_extract0 (
    .rdata    (rdata),
    .addr_lo  (addr_q[1:0]),
    .size_q   (size_q),
    .sext_q   (sext_q),
    .ext_data (ext_data)
  );

  // Read and write addresses share the captured request address
  axi_sram sram0 (
    .clock   (clock),
    .reset   (reset),
    .araddr  (addr_q),
    .arvalid (arvalid),
    .rready  (rready),
    .awaddr  (addr_q),
    .awvalid (awvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .bready  (bready),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .awready (awready),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid)
  );

endmodule

// ==== tb/lsu_checker.sv ====
`include "lsu_settings.svh"

module lsu_checker (
  input logic                   clock,
  input logic                   reset,
  input logic                   arvalid,
  input logic                   arready,
  input logic                   awvalid,
  input logic                   awready,
  input logic                   wvalid,
  input logic                   wready,
  input logic [`LSU_ADDR_W-1:0] addr_q,
  input logic [31:0]            wsrc_q,
  input logic                   block,
  input logic                   fault
);
  timeunit 1ns;
  timeprecision 100ps;

  int assert_fails = 0;  // Read by the testbench at the end

  ar_held: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(addr_q))
    else begin
      $error("arvalid or its address changed before arready");
      assert_fails++;
    end

  aw_held: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(addr_q))
    else begin
      $error("awvalid or its address changed before awready");
      assert_fails++;
    end

  w_held: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wsrc_q))
    else begin
      $error("wvalid or its data changed before wready");
      assert_fails++;
    end

  // Only one access in flight
  one_addr: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && awvalid))
    else begin
      $error("arvalid and awvalid high together");
      assert_fails++;
    end

  fault_at_end: assert property (@(posedge clock) disable iff (reset)
    fault |-> !block && $past(block))
    else begin
      $error("fault outside the cycle where block fell");
      assert_fails++;
    end

endmodule

bind lsu_ctrl lsu_checker checker0 (
  .clock   (clock),
  .reset   (reset),
  .arvalid (arvalid),
  .arready (arready),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .addr_q  (addr_q),
  .wsrc_q  (wsrc_q),
  .block   (block),
  .fault   (fault)
);

// ==== tb/tb_top.sv ====
`include "lsu_settings.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int region_bytes = 64;  // Shadowed low memory
  // Room for 420 accesses of 12 cycles against 288 issued
  localparam int watchdog_ns = 420 * 12 * 10;

  logic                   clock;
  logic                   reset;
  logic                   ren;
  logic                   wen;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [31:0]            wsrc;
  lsu_pkg::size_e         size;
  logic                   sext;
  logic [31:0]            exu_r_wdata;
  logic [31:0]            r_wdata;
  logic                   block;
  logic                   fault;

  logic [7:0]  shadow [region_bytes];
  logic [31:0] rng_state = 32'd36;
  int          errors;
  int          tests_run;
  int          tests_failed;

  lsu_top dut0 (
    .clock       (clock),
    .reset       (reset),
    .ren         (ren),
    .wen         (wen),
    .addr        (addr),
    .wsrc        (wsrc),
    .size        (size),
    .sext        (sext),
    .exu_r_wdata (exu_r_wdata),
    .r_wdata     (r_wdata),
    .block       (block),
    .fault       (fault)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, tests did not finish", watchdog_ns);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Little endian view of the shadow bytes
  function automatic logic [31:0] expect_load(input logic [5:0] a, input lsu_pkg::size_e sz,
                                              input logic sx);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[a];
    h = {shadow[a + 6'd1], b};
    case (sz)
      lsu_pkg::size_byte: return sx ? {{24{b[7]}}, b} : {24'd0, b};
      lsu_pkg::size_half: return sx ? {{16{h[15]}}, h} : {16'd0, h};
      default:            return {shadow[a + 6'd3], shadow[a + 6'd2], h};
    endcase
  endfunction

  task automatic shadow_store(input logic [5:0] a, input lsu_pkg::size_e sz,
                              input logic [31:0] d);
    shadow[a] = d[7:0];
    if (sz != lsu_pkg::size_byte)
      shadow[a + 6'd1] = d[15:8];
    if (sz == lsu_pkg::size_word) begin
      shadow[a + 6'd2] = d[23:16];
      shadow[a + 6'd3] = d[31:24];
    end
  endtask

  // Called 1 ns after an edge with block low
  task automatic run_access(input logic is_wr, input logic [31:0] a, input lsu_pkg::size_e sz,
                            input logic sx, input logic [31:0] d,
                            output logic [31:0] rd, output logic flt);
    int waited;
    ren  = ~is_wr;
    wen  = is_wr;
    addr = a;
    wsrc = d;
    size = sz;
    sext = sx;
    @(posedge clock);
    #1;
    ren    = 1'b0;
    wen    = 1'b0;
    waited = 0;
    while (block && waited < 200) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (block) begin
      $display("Access to 0x%08h never finished, block stayed high for 200 cycles", a);
      $display("Test FAILED");
      $finish;
    end else begin
      rd  = r_wdata;  // Valid in the cycle block falls
      flt = fault;
    end
  endtask

  task automatic store(input logic [31:0] a, input lsu_pkg::size_e sz, input logic [31:0] d);
    logic [31:0] rd;
    logic        flt;
    run_access(1'b1, a, sz, 1'b0, d, rd, flt);
    shadow_store(a[5:0], sz, d);
    if (flt !== 1'b0) begin
      $display("ERR %0t: store to 0x%08h size %0d raised fault", $time, a, sz);
      errors++;
    end
  endtask

  task automatic load_check(input logic [31:0] a, input lsu_pkg::size_e sz, input logic sx);
    logic [31:0] rd;
    logic        flt;
    logic [31:0] want;
    want = expect_load(a[5:0], sz, sx);
    run_access(1'b0, a, sz, sx, 32'd0, rd, flt);
    if (rd !== want || flt !== 1'b0) begin
      $display("ERR %0t: load 0x%08h size %0d sext %0b got 0x%08h fault %0b, expected 0x%08h",
               $time, a, sz, sx, rd, flt, want);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("%-14s passed", name);
    else begin
      tests_failed++;
      $display("%-14s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic reset_state();
    int          e0;
    logic [31:0] v;
    e0 = errors;
    if (block !== 1'b0 || fault !== 1'b0) begin
      $display("ERR %0t: block %b fault %b after reset", $time, block, fault);
      errors++;
    end
    for (int n = 0; n < 3; n++) begin
      v           = next_rand();
      exu_r_wdata = v;
      @(posedge clock);
      #1;
      if (r_wdata !== v) begin
        $display("ERR %0t: idle r_wdata 0x%08h, expected 0x%08h", $time, r_wdata, v);
        errors++;
      end
    end
    report_test("reset_state", e0);
  endtask

  task automatic word_access();
    int e0;
    e0 = errors;
    for (int i = 0; i < region_bytes / 4; i++)
      store(i * 4, lsu_pkg::size_word, next_rand());
    for (int i = region_bytes / 4 - 1; i >= 0; i--)
      load_check(i * 4, lsu_pkg::size_word, 1'b0);
    report_test("word_access", e0);
  endtask

  task automatic partial_stores();
    int e0;
    e0 = errors;
    for (int w = 1; w < 3; w++) begin
      for (int off = 0; off < 4; off++) begin
        store(w * 4 + off, lsu_pkg::size_byte, next_rand());
        load_check(w * 4, lsu_pkg::size_word, 1'b0);
      end
      for (int off = 0; off < 4; off += 2) begin
        store(w * 4 + off, lsu_pkg::size_half, next_rand());
        load_check(w * 4, lsu_pkg::size_word, 1'b0);
      end
      load_check(w * 4 + 4, lsu_pkg::size_word, 1'b0);  // Neighbour untouched
    end
    report_test("partial_store", e0);
  endtask

  task automatic sign_extension();
    int e0;
    e0 = errors;
    store(32'd12, lsu_pkg::size_word, 32'h8f7e_f180);
    store(32'd16, lsu_pkg::size_word, 32'h7f01_0123);
    for (int w = 12; w <= 16; w += 4) begin
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++)
          load_check(w + off, lsu_pkg::size_byte, s[0]);
        for (int off = 0; off < 4; off += 2)
          load_check(w + off, lsu_pkg::size_half, s[0]);
      end
    end
    report_test("extension", e0);
  endtask

  task automatic range_fault();
    int          e0;
    logic [31:0] far;
    logic [31:0] rd;
    logic        flt;
    e0  = errors;
    far = `LSU_SRAM_WORDS * 4;  // Same index bits as word 0
    run_access(1'b0, far + 4, lsu_pkg::size_word, 1'b0, 32'd0, rd, flt);
    if (flt !== 1'b1 || rd !== 32'd0) begin
      $display("ERR %0t: far load got 0x%08h fault %b, expected zero with fault", $time, rd, flt);
      errors++;
    end
    @(posedge clock);
    #1;
    if (fault !== 1'b0) begin
      $display("ERR %0t: fault held longer than one cycle after load", $time);
      errors++;
    end
    run_access(1'b1, far, lsu_pkg::size_word, 1'b0, 32'hffff_ffff, rd, flt);
    if (flt !== 1'b1) begin
      $display("ERR %0t: far store ended without fault", $time);
      errors++;
    end
    @(posedge clock);
    #1;
    if (fault !== 1'b0) begin
      $display("ERR %0t: fault held longer than one cycle after store", $time);
      errors++;
    end
    load_check(32'd0, lsu_pkg::size_word, 1'b0);
    load_check(32'd4, lsu_pkg::size_word, 1'b0);
    report_test("range_fault", e0);
  endtask

  task automatic random_mix();
    int             e0;
    logic [31:0]    r;
    logic [31:0]    a;
    lsu_pkg::size_e sz;
    e0 = errors;
    for (int n = 0; n < 200; n++) begin
      r = next_rand();
      case (r[2:1])
        2'd0:    sz = lsu_pkg::size_byte;
        2'd1:    sz = lsu_pkg::size_half;
        default: sz = lsu_pkg::size_word;
      endcase
      a = {26'd0, r[6:3], 2'b00};
      if (sz == lsu_pkg::size_byte)
        a[1:0] = r[8:7];
      else if (sz == lsu_pkg::size_half)
        a[1] = r[8];
      if (r[0])
        store(a, sz, next_rand());
      else
        load_check(a, sz, r[9]);
    end
    report_test("random_mix", e0);
  endtask

  initial begin
    reset        = 1'b1;
    ren          = 1'b0;
    wen          = 1'b0;
    addr         = '0;
    wsrc         = 32'd0;
    size         = lsu_pkg::size_word;
    sext         = 1'b0;
    exu_r_wdata  = 32'd0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    reset_state();
    word_access();
    partial_stores();
    sign_extension();
    range_fault();
    random_mix();

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut0.ctrl0.checker0.assert_fails);
    if (errors == 0 && dut0.ctrl0.checker0.assert_fails == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
src/lsu_pkg.sv
src/store_align.sv
src/load_extract.sv
src/lsu_ctrl.sv
src/axi_sram.sv
src/lsu_top.sv
tb/lsu_checker.sv
tb/tb_top.sv

// ==== Makefile ====
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f all.f --top-module tb_top -o sim_top

run: build
	./obj_dir/sim_top | tee $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -Wall \
		-f all.f --top-module tb_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
